// ==== tb.f ====
+incdir+src
src/isa_pkg.sv
src/datapath_pkg.sv
src/insn_decode.sv
src/bit_state.sv
src/serial_rf.sv
src/serial_alu.sv
src/serial_pc.sv
src/serial_core.sv
sim/serial_core_sva.sv
sim/tb_serial_core.sv

// ==== Makefile ====
SRCS := $(wildcard src/*.sv src/*.svh sim/*.sv)

.PHONY: run clean

obj_dir/Vtb_serial_core: tb.f $(SRCS)
	verilator --binary --timing --assert -f tb.f --top-module tb_serial_core -o Vtb_serial_core

run: obj_dir/Vtb_serial_core
	./obj_dir/Vtb_serial_core | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim/tb_serial_core.sv ====
`timescale 1ns/100ps

module tb_serial_core;

   logic                clk;
   logic                rst;
   logic                ack;
   datapath_pkg::word_t rdt;
   logic                cyc;
   datapath_pkg::word_t adr;

   datapath_pkg::word_t imem [64];
   datapath_pkg::word_t mregs [8];
   datapath_pkg::word_t prog [$];
   int                  max_delay;
   int                  gap;
   int                  errors;
   int                  err_mark;
   int                  checks;
   int                  tests;

   serial_core dut (
      .i_clk      (clk),
      .i_rst      (rst),
      .o_ibus_cyc (cyc),
      .o_ibus_adr (adr),
      .i_ibus_rdt (rdt),
      .i_ibus_ack (ack)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // the instruction memory answers each fetch after a random number of cycles
   always @(posedge clk) begin
      ack <= 1'b0;
      if (rst) begin
         gap <= $urandom % (max_delay + 1);
      end else if (cyc && !ack) begin
         if (gap == 0) begin
            ack <= 1'b1;
            rdt <= imem[adr[7:2]];
            gap <= $urandom % (max_delay + 1);
         end else begin
            gap <= gap - 1;
         end
      end
   end

   function automatic datapath_pkg::word_t enc_i(input int rd, input int rs1, input int imm);
      enc_i = {imm[11:0], 5'(rs1), 3'b000, 5'(rd), 7'h13};
   endfunction

   function automatic datapath_pkg::word_t enc_r(input int f3, input bit sub, input int rd,
                                                 input int rs1, input int rs2);
      enc_r = {1'b0, sub, 5'b0, 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'h33};
   endfunction

   function automatic datapath_pkg::word_t enc_b(input int f3, input int rs1, input int rs2,
                                                 input int off);
      logic [12:0] o;
      o = off[12:0];
      enc_b = {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], 7'h63};
   endfunction

   // skipped over by a taken branch, so a wrong outcome also shows up in x7
   task automatic filler();
      prog.push_back(enc_i(7, 7, 1));
   endtask

   task automatic check_adr(input string name, input datapath_pkg::word_t exp,
                            input datapath_pkg::word_t got);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail %s: expected %h got %h", name, exp, got);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic got);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail %s: expected %h got %h", name, exp, got);
      end
   endtask

   // RV32I rules for the kept instructions where x0 stays zero
   task automatic exec_model(input datapath_pkg::word_t insn, inout datapath_pkg::word_t pc);
      datapath_pkg::word_t a;
      datapath_pkg::word_t b;
      datapath_pkg::word_t res;
      logic [2:0]          f3;
      logic                taken;
      logic                wr;
      a     = mregs[insn[17:15]];
      b     = mregs[insn[22:20]];
      f3    = insn[14:12];
      taken = 1'b0;
      wr    = 1'b1;
      res   = '0;
      case (insn[6:0])
         7'h13: res = a + {{20{insn[31]}}, insn[31:20]};
         7'h33: begin
            if (f3 == 3'd2) res = ($signed(a) < $signed(b)) ? 1 : 0;
            else if (insn[30]) res = a - b;
            else res = a + b;
         end
         default: begin
            wr = 1'b0;
            case (f3)
               3'd0: taken = (a == b);
               3'd1: taken = (a != b);
               3'd4: taken = ($signed(a) < $signed(b));
               default: taken = ($signed(a) >= $signed(b));
            endcase
         end
      endcase
      if (wr && insn[9:7] != 0) mregs[insn[9:7]] = res;
      if (taken) pc = pc + {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
      else pc = pc + 4;
   endtask

   task automatic wait_fetch(output datapath_pkg::word_t a, output bit ok);
      int n;
      ok = 0;
      n  = 0;
      while (!ok && n < 500) begin
         @(posedge clk);
         n++;
         if (ack) begin
            ok = 1;
            a  = adr;
         end
      end
      if (!ok) begin
         errors++;
         $display("timeout, no instruction fetch was acknowledged within 500 cycles");
      end
   endtask

   // reset is taken right at a fetch acknowledge, before any register is written
   task automatic restart();
      rst <= 1'b1;
      for (int i = 0; i < 64; i++) begin
         imem[i] = (i < prog.size()) ? prog[i] : enc_i(0, 0, i);
      end
      repeat (10) @(posedge clk);
      rst <= 1'b0;
   endtask

   // follows the fetch stream until the address after the last instruction
   task automatic follow_program();
      datapath_pkg::word_t pc;
      datapath_pkg::word_t a;
      bit                  ok;
      int                  steps;
      pc    = '0;
      steps = 0;
      forever begin
         wait_fetch(a, ok);
         if (!ok) break;
         check_adr("o_ibus_adr", pc, a);
         if (pc == prog.size() * 4) break;
         if (steps == 300) begin
            errors++;
            $display("program did not reach its last address within 300 instructions");
            break;
         end
         exec_model(prog[pc[7:2]], pc);
         steps++;
      end
   endtask

   task automatic report_test(input string name);
      tests++;
      $display("%s: %0d errors", name, errors - err_mark);
      err_mark = errors;
   endtask

   task automatic test_reset();
      prog.delete();
      for (int r = 1; r < 8; r++) prog.push_back(enc_i(r, 0, $urandom));
      restart();
      repeat (2) @(posedge clk);
      check_flag("o_ibus_cyc", 1'b1, cyc);
      check_adr("o_ibus_adr", 32'h0, adr);
      follow_program();
      report_test("reset and register init");
   endtask

   task automatic test_straight();
      prog.delete();
      prog.push_back(enc_i(1, 0, $urandom));
      prog.push_back(enc_i(2, 0, $urandom));
      prog.push_back(enc_r(0, 0, 3, 1, 2));
      prog.push_back(enc_r(0, 1, 4, 3, 1));
      prog.push_back(enc_r(0, 0, 5, 4, 4));
      prog.push_back(enc_r(0, 1, 6, 2, 5));
      prog.push_back(enc_i(7, 6, $urandom));
      // x4 holds x2 again, so the equality branch exposes the add and sub
      prog.push_back(enc_b(0, 4, 2, 8));
      filler();
      prog.push_back(enc_b(1, 6, 2, 8));
      filler();
      restart();
      follow_program();
      report_test("straight-line add and sub");
   endtask

   task automatic test_eq_branch();
      int v;
      v = $urandom;
      prog.delete();
      prog.push_back(enc_i(1, 0, v));
      prog.push_back(enc_i(2, 0, v));
      prog.push_back(enc_b(0, 1, 2, 8));
      filler();
      prog.push_back(enc_b(1, 1, 2, 8));
      filler();
      prog.push_back(enc_i(4, 0, $urandom & 3));
      prog.push_back(enc_b(0, 4, 0, 8));
      filler();
      // in the count down loop the backward branch is taken until x5 reaches zero
      prog.push_back(enc_i(5, 0, 3));
      prog.push_back(enc_i(5, 5, -1));
      prog.push_back(enc_b(1, 5, 0, -4));
      prog.push_back(enc_b(0, 5, 0, 8));
      filler();
      restart();
      follow_program();
      report_test("beq and bne");
   endtask

   task automatic test_signed_branch();
      prog.delete();
      // x1 becomes the most negative word by doubling, x2 the most positive
      prog.push_back(enc_i(1, 0, 1));
      for (int i = 0; i < 31; i++) prog.push_back(enc_r(0, 0, 1, 1, 1));
      prog.push_back(enc_i(2, 1, -1));
      prog.push_back(enc_b(4, 1, 2, 8));
      filler();
      prog.push_back(enc_b(5, 2, 1, 8));
      filler();
      prog.push_back(enc_b(4, 2, 1, 8));
      filler();
      prog.push_back(enc_b(5, 1, 2, 8));
      filler();
      prog.push_back(enc_i(3, 0, $urandom));
      prog.push_back(enc_i(4, 0, $urandom));
      prog.push_back(enc_b(4, 3, 4, 8));
      filler();
      prog.push_back(enc_b(5, 3, 4, 8));
      filler();
      prog.push_back(enc_i(5, 0, -2));
      prog.push_back(enc_i(5, 5, 1));
      prog.push_back(enc_b(4, 5, 0, -4));
      restart();
      follow_program();
      report_test("blt and bge");
   endtask

   task automatic test_slt_x0();
      prog.delete();
      prog.push_back(enc_i(1, 0, $urandom));
      prog.push_back(enc_i(2, 0, $urandom));
      prog.push_back(enc_r(2, 0, 3, 1, 2));
      prog.push_back(enc_b(1, 3, 0, 8));
      filler();
      prog.push_back(enc_r(2, 0, 4, 2, 1));
      prog.push_back(enc_i(5, 0, 1));
      prog.push_back(enc_b(0, 4, 5, 8));
      filler();
      // x0 must ignore these writes and still compare equal to a zero register
      prog.push_back(enc_i(0, 0, $urandom | 1));
      prog.push_back(enc_i(6, 0, 0));
      prog.push_back(enc_b(1, 0, 6, 8));
      filler();
      prog.push_back(enc_r(0, 0, 0, 1, 5));
      prog.push_back(enc_b(0, 0, 6, 8));
      filler();
      restart();
      follow_program();
      report_test("slt and x0");
   endtask

   // the same program runs on a fast and a slow bus, and each run has to
   // follow the address sequence of the register model
   task automatic test_ack_delay();
      prog.delete();
      prog.push_back(enc_i(1, 0, 3));
      prog.push_back(enc_i(1, 1, -1));
      prog.push_back(enc_b(1, 1, 0, -4));
      prog.push_back(enc_i(2, 0, $urandom));
      prog.push_back(enc_r(2, 0, 3, 2, 1));
      prog.push_back(enc_b(0, 3, 0, 8));
      filler();
      max_delay = 0;
      restart();
      follow_program();
      max_delay = 7;
      restart();
      follow_program();
      report_test("ack delay");
   endtask

   initial begin
      rst       = 1'b1;
      ack       = 1'b0;
      rdt       = '0;
      max_delay = 3;
      errors    = 0;
      err_mark  = 0;
      checks    = 0;
      tests     = 0;
      foreach (mregs[i]) mregs[i] = '0;
      void'($urandom(32'haee4));
      test_reset();
      test_straight();
      test_eq_branch();
      test_signed_branch();
      test_slt_x0();
      test_ack_delay();
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// ==== sim/serial_core_sva.sv ====
`timescale 1ns/100ps

module serial_core_sva (
   input logic                i_clk,
   input logic                i_rst,
   input logic                i_ibus_cyc,
   input logic                i_ibus_ack,
   input datapath_pkg::word_t i_ibus_adr,
   input logic                i_cnt_en
);

   // a fetch that is not yet acknowledged must still be requested next cycle
   cyc_held : assert property (@(posedge i_clk) disable iff (i_rst)
      (i_ibus_cyc && !i_ibus_ack) |=> i_ibus_cyc)
      else $error("fetch strobe dropped before acknowledge");

   // the fetch address may not move under a pending request
   adr_stable : assert property (@(posedge i_clk) disable iff (i_rst)
      (i_ibus_cyc && !i_ibus_ack) |=> $stable(i_ibus_adr))
      else $error("fetch address changed during a pending fetch");

   // the bit counter only runs between acknowledge and the next fetch
   no_count_in_fetch : assert property (@(posedge i_clk) disable iff (i_rst)
      i_ibus_cyc |-> !i_cnt_en)
      else $error("bit counter running while a fetch is pending");

endmodule

bind serial_core serial_core_sva u_sva (
   .i_clk      (i_clk),
   .i_rst      (i_rst),
   .i_ibus_cyc (o_ibus_cyc),
   .i_ibus_ack (i_ibus_ack),
   .i_ibus_adr (o_ibus_adr),
   .i_cnt_en   (cnt_en)
);

// ==== src/serial_core.sv ====
`timescale 1ns/100ps

module serial_core (
   input  logic                i_clk,
   input  logic                i_rst,
   output logic                o_ibus_cyc,
   output datapath_pkg::word_t o_ibus_adr,
   input  datapath_pkg::word_t i_ibus_rdt,
   input  logic                i_ibus_ack
);

   isa_pkg::reg_idx_t rs1;
   isa_pkg::reg_idx_t rs2;
   isa_pkg::reg_idx_t rd;
   isa_pkg::alu_op_t  alu_op;
   logic branch_op;
   logic slt_op;
   logic cond_branch;
   logic bne_or_bge;
   logic rd_op;
   logic imm_bit;
   logic rf_rreq;
   logic rf_wreq;
   logic rf_ready;
   logic rf_rd_en;
   logic init;
   logic cnt_en;
   logic cnt0;
   logic cnt2;
   logic pc_en;
   logic jump;
   logic rs1_bit;
   logic rs2_bit;
   logic op_b_bit;
   logic sum_bit;
   logic cmp_eq;
   logic cmp_lt;
   logic alu_cmp;
   logic alu_en;
   logic wdata;

   // branches compare against rs2 while the immediate waits for the pc,
   // elsewhere one of the two is zero by decoding
   assign op_b_bit = branch_op ? rs2_bit : (rs2_bit | imm_bit);

   // the ALU holds still in the second phase of slt so its flag survives
   assign alu_en = cnt_en & (init | !slt_op);

   // signed compares report less-than, equality branches report equal
   assign alu_cmp = (alu_op == isa_pkg::ALU_CMP) ? cmp_lt : cmp_eq;

   // slt writes its flag into bit 0 and clears the rest of rd
   assign wdata = slt_op ? (cnt0 & cmp_lt) : sum_bit;

   insn_decode u_decode (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_ibus_rdt    (i_ibus_rdt),
      .i_ibus_ack    (i_ibus_ack),
      .i_cnt_en      (cnt_en),
      .o_rs1         (rs1),
      .o_rs2         (rs2),
      .o_rd          (rd),
      .o_alu_op      (alu_op),
      .o_branch_op   (branch_op),
      .o_slt_op      (slt_op),
      .o_cond_branch (cond_branch),
      .o_bne_or_bge  (bne_or_bge),
      .o_rd_op       (rd_op),
      .o_imm         (imm_bit)
   );

   bit_state u_state (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_ibus_ack    (i_ibus_ack),
      .o_ibus_cyc    (o_ibus_cyc),
      .o_rf_rreq     (rf_rreq),
      .o_rf_wreq     (rf_wreq),
      .i_rf_ready    (rf_ready),
      .o_rf_rd_en    (rf_rd_en),
      .i_cond_branch (cond_branch),
      .i_bne_or_bge  (bne_or_bge),
      .i_alu_cmp     (alu_cmp),
      .i_branch_op   (branch_op),
      .i_slt_op      (slt_op),
      .i_rd_op       (rd_op),
      .o_init        (init),
      .o_cnt_en      (cnt_en),
      .o_cnt0        (cnt0),
      .o_cnt2        (cnt2),
      .o_cnt_done    (),
      .o_ctrl_pc_en  (pc_en),
      .o_ctrl_jump   (jump)
   );

   serial_rf u_rf (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_rreq    (rf_rreq),
      .i_wreq    (rf_wreq),
      .o_ready   (rf_ready),
      .i_cnt_en  (cnt_en),
      .i_rs1     (rs1),
      .i_rs2     (rs2),
      .i_rd      (rd),
      .i_wen     (rf_rd_en),
      .i_wdata   (wdata),
      .o_rs1_bit (rs1_bit),
      .o_rs2_bit (rs2_bit)
   );

   serial_alu u_alu (
      .i_clk      (i_clk),
      .i_cnt_en   (alu_en),
      .i_cnt0     (cnt0),
      .i_op       (alu_op),
      .i_rs1_bit  (rs1_bit),
      .i_op_b_bit (op_b_bit),
      .o_sum_bit  (sum_bit),
      .o_cmp_eq   (cmp_eq),
      .o_cmp_lt   (cmp_lt)
   );

   serial_pc u_pc (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_pc_en (pc_en),
      .i_jump  (jump),
      .i_cnt0  (cnt0),
      .i_cnt2  (cnt2),
      .i_imm   (imm_bit),
      .o_pc    (o_ibus_adr)
   );

endmodule

// ==== src/serial_pc.sv ====
`timescale 1ns/100ps
`include "core_config.svh"

module serial_pc (
   input  logic                i_clk,
   input  logic                i_rst,
   input  logic                i_pc_en,
   input  logic                i_jump,
   input  logic                i_cnt0,
   input  logic                i_cnt2,
   input  logic                i_imm,
   output datapath_pkg::word_t o_pc
);

   datapath_pkg::word_t pc;
   logic                addend;
   logic                cin;
   logic                carry_q;
   logic                new_bit;

   // a taken branch adds the offset, otherwise a single 1 at bit 2 gives +4
   assign addend = i_jump ? i_imm : i_cnt2;

   // carry chain restarts with each new pass over the word
   assign cin     = carry_q & !i_cnt0;
   assign new_bit = pc[0] ^ addend ^ cin;

   // the pc rotates right through the adder, one bit per counter step,
   // so after 32 steps it holds the next fetch address
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         pc      <= '0;
         carry_q <= 1'b0;
      end else if (i_pc_en) begin
         pc      <= {new_bit, pc[`CORE_XLEN-1:1]};
         carry_q <= (pc[0] & addend) | (pc[0] & cin) | (addend & cin);
      end
   end

   // pc only moves while no fetch is outstanding, so the address is stable
   // for the whole bus cycle
   assign o_pc = pc;

endmodule

// ==== src/serial_alu.sv ====
`timescale 1ns/100ps

module serial_alu (
   input  logic             i_clk,
   input  logic             i_cnt_en,
   input  logic             i_cnt0,
   input  isa_pkg::alu_op_t i_op,
   input  logic             i_rs1_bit,
   input  logic             i_op_b_bit,
   output logic             o_sum_bit,
   output logic             o_cmp_eq,
   output logic             o_cmp_lt
);

   logic sub;
   logic b_bit;
   logic cin;
   logic carry_q;
   logic eq_q;
   logic lt_q;
   logic eq_now;
   logic ovf;
   logic lt_now;

   // subtraction is a + ~b + 1, the +1 enters as the carry into bit 0
   assign sub   = (i_op != isa_pkg::ALU_ADD);
   assign b_bit = i_op_b_bit ^ sub;
   assign cin   = i_cnt0 ? sub : carry_q;

   assign o_sum_bit = i_rs1_bit ^ b_bit ^ cin;

   // equality over all bits seen so far, restarted at bit 0
   assign eq_now = (i_cnt0 | eq_q) & !(i_rs1_bit ^ i_op_b_bit);

   // on the sign bit, a - b overflows when the operand signs differ and the
   // result sign does not follow a, the true sign is the result sign
   // corrected by that overflow
   assign ovf    = (i_rs1_bit ^ i_op_b_bit) & (o_sum_bit ^ i_rs1_bit);
   assign lt_now = o_sum_bit ^ ovf;

   always_ff @(posedge i_clk) begin
      if (i_cnt_en) begin
         carry_q <= (i_rs1_bit & b_bit) | (i_rs1_bit & cin) | (b_bit & cin);
         eq_q    <= eq_now;
         lt_q    <= lt_now;
      end
   end

   // live while running so the flags are ready in the last init cycle,
   // held once the ALU is stopped so stage two can still read them
   assign o_cmp_eq = i_cnt_en ? eq_now : eq_q;
   assign o_cmp_lt = i_cnt_en ? lt_now : lt_q;

endmodule

// ==== src/serial_rf.sv ====
`timescale 1ns/100ps
`include "core_config.svh"

module serial_rf (
   input  logic              i_clk,
   input  logic              i_rst,
   input  logic              i_rreq,
   input  logic              i_wreq,
   output logic              o_ready,
   input  logic              i_cnt_en,
   input  isa_pkg::reg_idx_t i_rs1,
   input  isa_pkg::reg_idx_t i_rs2,
   input  isa_pkg::reg_idx_t i_rd,
   input  logic              i_wen,
   input  logic              i_wdata,
   output logic              o_rs1_bit,
   output logic              o_rs2_bit
);

   datapath_pkg::word_t    regs [`CORE_RF_REGS];
   datapath_pkg::word_t    rs1_sr;
   datapath_pkg::word_t    rs2_sr;
   logic [`CORE_RF_LAT-1:0] lat;

   // every request travels down a short delay line and pops out as ready
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         lat <= '0;
      end else begin
         lat <= {lat[`CORE_RF_LAT-2:0], i_rreq | i_wreq};
      end
   end

   assign o_ready = lat[`CORE_RF_LAT-1];

   // operands are copied out at ready, the counter starts one cycle later
   // and then they rotate LSB first, x0 always comes out as zero
   always_ff @(posedge i_clk) begin
      if (o_ready) begin
         rs1_sr <= (i_rs1 == '0) ? '0 : regs[i_rs1];
         rs2_sr <= (i_rs2 == '0) ? '0 : regs[i_rs2];
      end else if (i_cnt_en) begin
         rs1_sr <= {rs1_sr[0], rs1_sr[`CORE_XLEN-1:1]};
         rs2_sr <= {rs2_sr[0], rs2_sr[`CORE_XLEN-1:1]};
      end
   end

   assign o_rs1_bit = rs1_sr[0];
   assign o_rs2_bit = rs2_sr[0];

   // destination is shifted in from the top, after 32 steps the first bit
   // written has reached bit 0
   // rd may equal a source because the sources were copied beforehand
   always_ff @(posedge i_clk) begin
      if (i_cnt_en & i_wen & (i_rd != '0)) begin
         regs[i_rd] <= {i_wdata, regs[i_rd][`CORE_XLEN-1:1]};
      end
   end

endmodule

// ==== src/bit_state.sv ====
`timescale 1ns/100ps

module bit_state (
   input  logic i_clk,
   input  logic i_rst,
   input  logic i_ibus_ack,
   output logic o_ibus_cyc,
   output logic o_rf_rreq,
   output logic o_rf_wreq,
   input  logic i_rf_ready,
   output logic o_rf_rd_en,
   input  logic i_cond_branch,
   input  logic i_bne_or_bge,
   input  logic i_alu_cmp,
   input  logic i_branch_op,
   input  logic i_slt_op,
   input  logic i_rd_op,
   output logic o_init,
   output logic o_cnt_en,
   output logic o_cnt0,
   output logic o_cnt2,
   output logic o_cnt_done,
   output logic o_ctrl_pc_en,
   output logic o_ctrl_jump
);

   datapath_pkg::bitcnt_t cnt;
   logic [3:0]            cnt_r;
   logic                  init_done;
   logic                  stage_two_req;
   logic                  boot;
   logic                  two_stage_op;
   logic                  take_branch;

   // the counter is running whenever a bit sits somewhere in the ring
   assign o_cnt_en = |cnt_r;

   // bit 0 and bit 2 of the word are the first and third ring positions
   // while the upper counter is still zero
   assign o_cnt0 = (cnt == '0) & cnt_r[0];
   assign o_cnt2 = (cnt == '0) & cnt_r[2];

   // slt and the branches need a compare before they can commit anything
   assign two_stage_op = i_slt_op | i_branch_op;

   // the first phase of a two-stage op is init, which ends once init_done is set
   assign o_init = two_stage_op & !init_done;

   // pc moves in the phase that finishes the instruction
   assign o_ctrl_pc_en = o_cnt_en & !o_init;

   // rd is written in that same phase, never during init
   assign o_rf_rd_en = i_rd_op & o_cnt_en & !o_init;

   // branch is taken when the compare result differs from the inversion bit
   // carried by bne and bge, and this is only meaningful in the last cycle of init
   assign take_branch = i_cond_branch & (i_alu_cmp ^ i_bne_or_bge);

   // register file is asked for operands right at the fetch acknowledge,
   // and again when a two-stage op enters its second phase
   assign o_rf_rreq = i_ibus_ack | stage_two_req;

   // the write phase of a two-stage op is requested as init finishes
   assign o_rf_wreq = stage_two_req;

   always_ff @(posedge i_clk) begin
      // fetch strobe drops on acknowledge and comes back once the phase that
      // updated the pc has finished, while boot starts the very first fetch
      if (i_ibus_ack | o_cnt_done | boot) begin
         o_ibus_cyc <= o_ctrl_pc_en | boot;
      end
      boot <= 1'b0;

      // init_done toggles on at the end of init and off after phase two,
      // and the branch decision is captured at the same moment
      if (o_cnt_done) begin
         init_done   <= o_init & !init_done;
         o_ctrl_jump <= o_init & take_branch;
      end

      // done flags the 32nd step, the last ring position of the last group
      o_cnt_done <= (cnt == '1) & cnt_r[2];

      // one cycle strobe in the idle gap between init and phase two
      stage_two_req <= o_cnt_done & o_init;

      // upper counter advances each time the ring wraps
      cnt <= cnt + {2'b00, cnt_r[3]};

      // ready from the register file injects the starting bit,
      // while done keeps the wrapping bit from going round again
      cnt_r <= {cnt_r[2:0], (cnt_r[3] & !o_cnt_done) | (i_rf_ready & !o_cnt_en)};

      if (i_rst) begin
         o_ibus_cyc    <= 1'b0;
         boot          <= 1'b1;
         init_done     <= 1'b0;
         o_ctrl_jump   <= 1'b0;
         o_cnt_done    <= 1'b0;
         stage_two_req <= 1'b0;
         cnt           <= '0;
         cnt_r         <= 4'b0000;
      end
   end

endmodule

// ==== src/insn_decode.sv ====
`timescale 1ns/100ps
`include "core_config.svh"

module insn_decode (
   input  logic                i_clk,
   input  logic                i_rst,
   input  datapath_pkg::word_t i_ibus_rdt,
   input  logic                i_ibus_ack,
   input  logic                i_cnt_en,
   output isa_pkg::reg_idx_t   o_rs1,
   output isa_pkg::reg_idx_t   o_rs2,
   output isa_pkg::reg_idx_t   o_rd,
   output isa_pkg::alu_op_t    o_alu_op,
   output logic                o_branch_op,
   output logic                o_slt_op,
   output logic                o_cond_branch,
   output logic                o_bne_or_bge,
   output logic                o_rd_op,
   output logic                o_imm
);

   datapath_pkg::word_t insn;
   datapath_pkg::word_t imm_sr;
   isa_pkg::opcode_t    opcode;
   logic [2:0]          funct3;
   logic                is_op;
   logic                is_op_imm;

   // the instruction word is held for the whole execution of the instruction
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         insn <= '0;
      end else if (i_ibus_ack) begin
         insn <= i_ibus_rdt;
      end
   end

   // immediate is loaded straight from the bus and then rotated LSB first,
   // so after a full 32-step phase it is back in place for a second phase
   always_ff @(posedge i_clk) begin
      if (i_ibus_ack) begin
         case (i_ibus_rdt[6:0])
            isa_pkg::OP_IMM:
               imm_sr <= {{20{i_ibus_rdt[31]}}, i_ibus_rdt[31:20]};
            isa_pkg::BRANCH:
               imm_sr <= {{19{i_ibus_rdt[31]}}, i_ibus_rdt[31], i_ibus_rdt[7],
                          i_ibus_rdt[30:25], i_ibus_rdt[11:8], 1'b0};
            // register ops see a zero immediate on operand b
            default:
               imm_sr <= '0;
         endcase
      end else if (i_cnt_en) begin
         imm_sr <= {imm_sr[0], imm_sr[`CORE_XLEN-1:1]};
      end
   end

   assign o_imm = imm_sr[0];

   assign opcode    = isa_pkg::opcode_t'(insn[6:0]);
   assign funct3    = insn[14:12];
   assign is_op     = (opcode == isa_pkg::OP);
   assign is_op_imm = (opcode == isa_pkg::OP_IMM);

   assign o_branch_op   = (opcode == isa_pkg::BRANCH);
   // all kept branches are conditional, opcode bit 2 would mark a jump
   assign o_cond_branch = o_branch_op & !insn[2];
   assign o_bne_or_bge  = funct3[0];
   assign o_slt_op      = is_op & (funct3 == 3'b010);
   assign o_rd_op       = is_op | is_op_imm;

   assign o_rs1 = insn[17:15];
   // immediate ops read x0 as rs2 so only the immediate reaches operand b
   assign o_rs2 = is_op_imm ? '0 : insn[22:20];
   assign o_rd  = insn[9:7];

   always_comb begin
      if (o_slt_op | (o_branch_op & funct3[2])) begin
         o_alu_op = isa_pkg::ALU_CMP;
      end else if (o_branch_op | (is_op & insn[30])) begin
         o_alu_op = isa_pkg::ALU_SUB;
      end else begin
         o_alu_op = isa_pkg::ALU_ADD;
      end
   end

endmodule

// ==== src/datapath_pkg.sv ====
`include "core_config.svh"

package datapath_pkg;

   // instruction words, addresses and register contents
   typedef logic [`CORE_XLEN-1:0] word_t;

   // upper part of the bit counter, the two low bits live in a 4-bit ring
   typedef logic [$clog2(`CORE_XLEN/4)-1:0] bitcnt_t;

endpackage

// ==== src/isa_pkg.sv ====
`include "core_config.svh"

package isa_pkg;

   // index into the register file, the low bits of the rs1, rs2 and rd fields
   typedef logic [$clog2(`CORE_RF_REGS)-1:0] reg_idx_t;

   // major opcodes understood by the core, RV32I encodings
   typedef enum logic [6:0] {
      OP_IMM = 7'b0010011,
      OP     = 7'b0110011,
      BRANCH = 7'b1100011
   } opcode_t;

   // operation applied by the serial ALU
   // equality branches subtract and watch for a zero result,
   // signed order compares (slt, blt, bge) use ALU_CMP
   typedef enum logic [1:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_CMP
   } alu_op_t;

endpackage

// ==== src/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// width of a data word, one bit of it is processed per counter step
`define CORE_XLEN 32

// number of architectural registers held in the register file
`define CORE_RF_REGS 8

// cycles from a register file request until ready is signalled
`define CORE_RF_LAT 2

`endif
